// ==== verilog.f ====
hdl/board_pkg.sv
hdl/panel_pkg.sv
hdl/clock_rate_gen.sv
hdl/reset_sequencer.sv
hdl/pc_display.sv
hdl/board_support_top.sv
verif/board_support_props.sv
verif/board_support_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the board support subsystem

VERILATOR ?= verilator
TOP       ?= board_support_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/board_support_tb.sv ====
// directed self-checking testbench for the board support subsystem
`default_nettype none
`timescale 1ns/1ns

module board_support_tb;

   localparam int SIG_DCM   = 0;
   localparam int SIG_RST   = 1;
   localparam int SIG_BOOT  = 2;
   localparam int SIG_HALT  = 3;
   localparam int SIG_STEP  = 4;
   localparam int SIG_C50   = 5;
   localparam int PRESS_MAX = 40;    // debounce latency is about 19 cycles
   localparam int SCAN_MAX  = 300;   // one full scan is 256 cycles

   // segments g f e d c b a for digits 0 to f
   localparam logic [6:0] SEG_TABLE [16] = '{
      7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111,
      7'b1100110, 7'b1101101, 7'b1111101, 7'b0000111,
      7'b1111111, 7'b1101111, 7'b1110111, 7'b1111100,
      7'b0111001, 7'b1011110, 7'b1111001, 7'b1110001};

   logic        clk100, rst_n, machrun;
   logic [3:0]  button, cpu_state, bus_state;
   logic [6:0]  rate_sw;
   logic [13:0] pc;
   logic [4:0]  disk_state;
   logic        dcm_reset, cpu_reset, cpu_boot, cpu_halt, cpu_step, clk50_en;
   logic [7:0]  led, sevenseg;
   logic [3:0]  sevenseg_an;
   int          value_errors, timeout_errors, seed;

   board_support_top i_board_support_top (.*);

   initial begin
      clk100 = 1'b0;
      forever #10 clk100 = ~clk100;
   end

   // ----------------------------------------
   // helpers and compare tasks
   // ----------------------------------------
   task automatic step();
      @(posedge clk100);
      #2;   // sample and drive just after the edge
   endtask

   function automatic logic probe(input int which);
      case (which)
         SIG_DCM:  return dcm_reset;
         SIG_RST:  return cpu_reset;
         SIG_BOOT: return cpu_boot;
         SIG_HALT: return cpu_halt;
         SIG_C50:  return clk50_en;
         default:  return cpu_step;
      endcase
   endfunction

   task automatic wait_level(input int which, input logic level, input int limit,
                             input string what);
      int n;
      n = 0;
      while (probe(which) !== level && n < limit) begin
         step();
         n++;
      end
      if (probe(which) !== level) begin
         $display("timeout at %0t ns waiting for %s", $time, what);
         timeout_errors++;
      end
   endtask

   task automatic pulse_width(input int which, output int width);
      width = 0;
      while (probe(which) === 1'b1 && width < 1000) begin
         width++;
         step();
      end
   endtask

   task automatic press(input int b, input int hold);
      button[b] = 1'b1;
      repeat (hold) step();
      button[b] = 1'b0;
      repeat (24) step();   // let the release settle too
   endtask

   task automatic check_bit(input logic actual, input logic expected, input string what);
      if (actual !== expected) begin
         $display("FAIL %0t ns: %s is %b, expected %b", $time, what, actual, expected);
         value_errors++;
      end
   endtask

   task automatic check_count(input int actual, input int expected, input string what);
      if (actual != expected) begin
         $display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
         value_errors++;
      end
   endtask

   task automatic check_seg(input logic [7:0] actual, input logic [7:0] expected,
                            input string what);
      if (actual !== expected) begin
         $display("FAIL %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         value_errors++;
      end
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic test_power_up();
      int w;
      pulse_width(SIG_DCM, w);
      check_count(w, 8, "dcm_reset cycles");
      pulse_width(SIG_RST, w);
      check_count(w, 16, "cpu_reset cycles after dcm_reset");
      pulse_width(SIG_BOOT, w);
      check_count(w, 1, "cpu_boot cycles");
      check_bit(cpu_reset, 1'b0, "cpu_reset after power-up");
      check_bit(cpu_halt, 1'b0, "cpu_halt after power-up");
   endtask

   task automatic measure_step(input logic [6:0] sw, input int expected);
      int n;
      rate_sw = sw;
      step();
      wait_level(SIG_STEP, 1'b1, 2 * expected + 8, "cpu_step");
      n = 0;
      do begin
         step();
         n++;
      end while (!cpu_step && n < 2 * expected + 8);
      check_count(n, expected, $sformatf("cpu_step period, rate_sw %b", sw));
   endtask

   task automatic test_step_rates();
      int   taps [6] = '{0, 1, 2, 4, 5, 6};
      logic half;
      // clk50 enable alternates on every clk100 cycle
      wait_level(SIG_C50, 1'b1, 4, "clk50_en");
      half = 1'b1;
      repeat (8) begin
         check_bit(clk50_en, half, "clk50_en");
         half = ~half;
         step();
      end
      measure_step(7'b0, 2);
      for (int i = 0; i < 6; i++)
         measure_step(7'(1 << i), 1 << (taps[i] + 2));
      measure_step(7'b0100010, 256);   // bit 5 beats bit 1
      rate_sw = 7'b0;
   endtask

   task automatic test_buttons();
      int  w;
      int  n;
      logic seen;
      button[3] = 1'b1;
      wait_level(SIG_RST, 1'b1, PRESS_MAX, "cpu_reset after reset press");
      check_bit(led[0], 1'b1, "led[0] with cpu_reset");
      pulse_width(SIG_RST, w);
      check_count(w, 16, "cpu_reset cycles after reset press");
      pulse_width(SIG_BOOT, w);
      check_count(w, 1, "cpu_boot cycles after reset press");
      check_bit(led[0], 1'b0, "led[0] after boot");
      button[3] = 1'b0;
      repeat (24) step();
      // boot press, no reset expected
      button[2] = 1'b1;
      n = 0;
      seen = 1'b0;
      while (!cpu_boot && n < PRESS_MAX) begin
         step();
         n++;
         seen = seen | cpu_reset;
      end
      check_bit(cpu_boot, 1'b1, "cpu_boot after boot press");
      check_bit(seen, 1'b0, "cpu_reset during boot press");
      step();
      check_bit(cpu_boot, 1'b0, "cpu_boot one cycle later");
      button[2] = 1'b0;
      repeat (24) step();
      // short press, ignored
      button[3] = 1'b1;
      repeat (10) step();
      button[3] = 1'b0;
      seen = 1'b0;
      repeat (PRESS_MAX) begin
         step();
         seen = seen | cpu_reset | cpu_boot;
      end
      check_bit(seen, 1'b0, "reset or boot after short press");
   endtask

   task automatic test_halt();
      press(1, 30);
      wait_level(SIG_HALT, 1'b1, PRESS_MAX, "cpu_halt set");
      check_bit(led[1], 1'b1, "led[1] with halt set");
      press(0, 30);
      wait_level(SIG_HALT, 1'b0, PRESS_MAX, "cpu_halt cleared");
      check_bit(led[1], 1'b0, "led[1] with halt cleared");
      press(1, 30);
      wait_level(SIG_HALT, 1'b1, PRESS_MAX, "cpu_halt set again");
      button[3] = 1'b1;
      wait_level(SIG_RST, 1'b1, PRESS_MAX, "cpu_reset after reset press");
      step();
      check_bit(cpu_halt, 1'b0, "cpu_halt during cpu_reset");
      button[3] = 1'b0;
      wait_level(SIG_BOOT, 1'b1, PRESS_MAX, "cpu_boot after reset press");
      repeat (24) step();
   endtask

   task automatic test_display();
      int          n;
      logic [15:0] pc_ext;
      logic [3:0]  nib;
      logic        dot;
      repeat (4) begin
         for (int mr = 0; mr < 2; mr++) begin
            pc        = 14'($random(seed));
            cpu_state = 4'($random(seed));
            bus_state = 4'($random(seed));
            machrun   = 1'(mr);
            step();                       // new inputs reach the registers
            pc_ext = {2'b00, pc};
            for (int k = 0; k < 4; k++) begin
               n = 0;
               while (sevenseg_an !== ~(4'b0001 << k) && n < SCAN_MAX) begin
                  step();
                  n++;
               end
               if (n >= SCAN_MAX) begin
                  $display("timeout at %0t ns waiting for anode %0d", $time, k);
                  timeout_errors++;
               end
               nib = pc_ext[k * 4 +: 4];
               dot = machrun ? cpu_state[k] : bus_state[k];
               check_seg(sevenseg, {~dot, ~SEG_TABLE[nib]},
                         $sformatf("sevenseg digit %0d, pc %h", k, pc));
            end
         end
      end
   endtask

   task automatic test_leds();
      repeat (4) begin
         disk_state = 5'($random(seed));
         machrun    = 1'($random(seed));
         step();
         check_seg({led[7:2], 2'b00}, {disk_state, machrun, 2'b00}, "led[7:2]");
      end
   endtask

   initial begin
      seed = 32'h7825_8a4d;
      value_errors = 0;
      timeout_errors = 0;
      rst_n = 1'b0;
      button = '0;
      rate_sw = '0;
      pc = '0;
      machrun = 1'b0;
      cpu_state = '0;
      bus_state = '0;
      disk_state = '0;
      repeat (4) @(posedge clk100);
      #2 rst_n = 1'b1;
      test_power_up();
      test_step_rates();
      test_buttons();
      test_halt();
      test_display();
      test_leds();
      $display("errors: %0d value, %0d timeout, %0d assertion", value_errors,
               timeout_errors, i_board_support_top.i_props.fail_count);
      if (value_errors + timeout_errors + i_board_support_top.i_props.fail_count == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/board_support_props.sv ====
// concurrent checks on the reset, step and display outputs of the board support top
`default_nettype none
`timescale 1ns/1ns

module board_support_props (
   input logic       clk100,
   input logic       rst_n,
   input logic       cpu_reset,
   input logic       cpu_boot,
   input logic       cpu_step,
   input logic [3:0] sevenseg_an
);
   int fail_count = 0;   // read by the testbench summary

   a_reset_boot: assert property (@(posedge clk100) disable iff (!rst_n)
      !(cpu_reset && cpu_boot))
   else begin
      fail_count++;
      $error("cpu_reset and cpu_boot high together");
   end

   // a step enable is a single cycle pulse
   a_step_single: assert property (@(posedge clk100) disable iff (!rst_n)
      cpu_step |=> !cpu_step)
   else begin
      fail_count++;
      $error("cpu_step high in two consecutive cycles");
   end

   // first edge after reset still shows the reset value
   a_one_anode: assert property (@(posedge clk100) disable iff (!rst_n)
      $past(rst_n) |-> $onehot(~sevenseg_an))
   else begin
      fail_count++;
      $error("not exactly one anode active");
   end

endmodule

bind board_support_top board_support_props i_props (
   .clk100      (clk100),
   .rst_n       (rst_n),
   .cpu_reset   (cpu_reset),
   .cpu_boot    (cpu_boot),
   .cpu_step    (cpu_step),
   .sevenseg_an (sevenseg_an)
);

`default_nettype wire

// ==== hdl/board_support_top.sv ====
// board support top level: step rate, reset sequencing, pc display and leds
`default_nettype none
`timescale 1ns/1ns

module board_support_top (
   input  logic        clk100,
   input  logic        rst_n,
   input  logic [3:0]  button,
   input  logic [6:0]  rate_sw,
   input  logic [13:0] pc,
   input  logic        machrun,
   input  logic [3:0]  cpu_state,
   input  logic [3:0]  bus_state,
   input  logic [4:0]  disk_state,
   output logic        dcm_reset,
   output logic        cpu_reset,
   output logic        cpu_boot,
   output logic        cpu_halt,
   output logic        cpu_step,
   output logic        clk50_en,
   output logic [7:0]  led,
   output logic [7:0]  sevenseg,
   output logic [3:0]  sevenseg_an
);

   // ----------------------------------------
   // enables
   // ----------------------------------------
   clock_rate_gen i_clock_rate_gen (
      .clk100   (clk100),
      .rst_n    (rst_n),
      .rate_sw  (rate_sw),
      .clk50_en (clk50_en),
      .cpu_step (cpu_step)
   );

   reset_sequencer i_reset_sequencer (
      .clk100    (clk100),
      .rst_n     (rst_n),
      .button    (button),
      .dcm_reset (dcm_reset),
      .cpu_reset (cpu_reset),
      .cpu_boot  (cpu_boot),
      .cpu_halt  (cpu_halt)
   );

   // ----------------------------------------
   // front panel
   // ----------------------------------------
   pc_display i_pc_display (
      .clk100      (clk100),
      .rst_n       (rst_n),
      .pc          (pc),
      .machrun     (machrun),
      .cpu_state   (cpu_state),
      .bus_state   (bus_state),
      .sevenseg    (sevenseg),
      .sevenseg_an (sevenseg_an)
   );

   assign led[7:3] = disk_state;
   assign led[2]   = machrun;
   assign led[1]   = cpu_halt;
   assign led[0]   = cpu_reset;

endmodule

`default_nettype wire

// ==== hdl/pc_display.sv ====
// four digit multiplexed hex display of the program counter with status dots
`default_nettype none
`timescale 1ns/1ns

module pc_display (
   input  logic        clk100,
   input  logic        rst_n,
   input  logic [13:0] pc,
   input  logic        machrun,
   input  logic [3:0]  cpu_state,
   input  logic [3:0]  bus_state,
   output logic [7:0]  sevenseg,      // dp g f e d c b a, active low
   output logic [3:0]  sevenseg_an    // active low
);
   import panel_pkg::*;

   logic [SCAN_WIDTH-1:0] scan_cnt;
   digit_t                digit;
   logic [15:0]           pc_ext;
   logic [3:0]            nibble;
   logic [3:0]            dots;

   assign pc_ext = {2'b00, pc};                   // top digit has only two bits
   assign nibble = pc_ext[{digit, 2'b00} +: 4];
   assign dots   = machrun ? cpu_state : bus_state;

   // ----------------------------------------
   // digit scan
   // ----------------------------------------
   always_ff @(posedge clk100 or negedge rst_n) begin
      if (!rst_n) begin
         scan_cnt <= '0;
         digit    <= DIG0;
      end else begin
         scan_cnt <= scan_cnt + 1'b1;
         if (scan_cnt == SCAN_WIDTH'(SCAN_CYCLES - 1))
            digit <= digit_t'(digit + 2'd1);      // wraps DIG3 -> DIG0
      end
   end

   // anodes and segments registered together
   always_ff @(posedge clk100 or negedge rst_n) begin
      if (!rst_n) begin
         sevenseg_an <= 4'b1111;
         sevenseg    <= 8'hff;
      end else begin
         sevenseg_an <= ~(4'b0001 << digit);
         sevenseg    <= {~dots[digit], ~hex_to_seg(nibble)};
      end
   end

endmodule

`default_nettype wire

// ==== hdl/reset_sequencer.sv ====
// button debouncing and power-up, reset, boot and halt control for the cpu
`default_nettype none
`timescale 1ns/1ns

module reset_sequencer (
   input  logic       clk100,
   input  logic       rst_n,
   input  logic [3:0] button,     // 3 reset, 2 boot, 1 halt, 0 continue
   output logic       dcm_reset,
   output logic       cpu_reset,
   output logic       cpu_boot,
   output logic       cpu_halt
);
   import board_pkg::*;

   logic [3:0]                btn_meta;
   logic [3:0]                btn_sync;
   logic [3:0]                btn_level;   // debounced level
   logic [3:0]                press;       // one cycle per accepted press
   logic [DEBOUNCE_WIDTH-1:0] db_cnt [4];
   seq_state_t                state;
   logic [SEQ_CNT_WIDTH-1:0]  seq_cnt;

   // ----------------------------------------
   // synchroniser and debounce
   // ----------------------------------------
   always_ff @(posedge clk100 or negedge rst_n) begin
      if (!rst_n) begin
         btn_meta  <= '0;
         btn_sync  <= '0;
         btn_level <= '0;
         press     <= '0;
         for (int i = 0; i < 4; i++)
            db_cnt[i] <= '0;
      end else begin
         btn_meta <= button;
         btn_sync <= btn_meta;
         for (int i = 0; i < 4; i++) begin
            press[i] <= 1'b0;
            if (btn_sync[i] == btn_level[i]) begin
               db_cnt[i] <= '0;                  // bounce restarts the count
            end else if (db_cnt[i] == DEBOUNCE_WIDTH'(DEBOUNCE_CYCLES - 1)) begin
               db_cnt[i]    <= '0;
               btn_level[i] <= btn_sync[i];
               press[i]     <= btn_sync[i];      // rising edges only
            end else begin
               db_cnt[i] <= db_cnt[i] + 1'b1;
            end
         end
      end
   end

   // ----------------------------------------
   // sequencer
   // ----------------------------------------
   always_ff @(posedge clk100 or negedge rst_n) begin
      if (!rst_n) begin
         state   <= SEQ_DCM;
         seq_cnt <= '0;
      end else begin
         case (state)
            SEQ_DCM: begin
               if (seq_cnt == SEQ_CNT_WIDTH'(DCM_RESET_CYCLES - 1)) begin
                  state   <= SEQ_RESET;
                  seq_cnt <= '0;
               end else begin
                  seq_cnt <= seq_cnt + 1'b1;
               end
            end
            SEQ_RESET: begin
               if (seq_cnt == SEQ_CNT_WIDTH'(RESET_CYCLES - 1)) begin
                  state   <= SEQ_BOOT;
                  seq_cnt <= '0;
               end else begin
                  seq_cnt <= seq_cnt + 1'b1;
               end
            end
            SEQ_BOOT: state <= SEQ_RUN;
            default: begin
               if (press[3]) begin                // reset wins over boot
                  state   <= SEQ_RESET;
                  seq_cnt <= '0;
               end else if (press[2]) begin
                  state <= SEQ_BOOT;
               end
            end
         endcase
      end
   end

   // halt flag, any cpu reset clears it
   always_ff @(posedge clk100 or negedge rst_n) begin
      if (!rst_n)
         cpu_halt <= 1'b0;
      else if (cpu_reset || press[0])
         cpu_halt <= 1'b0;
      else if (press[1])
         cpu_halt <= 1'b1;
   end

   assign dcm_reset = (state == SEQ_DCM);
   // cpu stays in reset while the clocks settle
   assign cpu_reset = (state == SEQ_DCM) || (state == SEQ_RESET);
   assign cpu_boot  = (state == SEQ_BOOT);

endmodule

`default_nettype wire

// ==== hdl/clock_rate_gen.sv ====
// clk50 enable and switch selected cpu step enable from a free-running counter
`default_nettype none
`timescale 1ns/1ns

module clock_rate_gen (
   input  logic       clk100,
   input  logic       rst_n,
   input  logic [6:0] rate_sw,
   output logic       clk50_en,
   output logic       cpu_step
);
   import board_pkg::*;

   logic                  phase;
   logic [SLOW_WIDTH-1:0] slow;
   logic [SLOW_WIDTH-1:0] tap_mask;
   step_rate_t            rate_sel;
   step_rate_t            rate_q;

   // highest switch wins
   always_comb begin
      if (rate_sw[6])      rate_sel = RATE_TAP18;
      else if (rate_sw[5]) rate_sel = RATE_TAP6;
      else if (rate_sw[4]) rate_sel = RATE_TAP5;
      else if (rate_sw[3]) rate_sel = RATE_TAP4;
      else if (rate_sw[2]) rate_sel = RATE_TAP2;
      else if (rate_sw[1]) rate_sel = RATE_TAP1;
      else if (rate_sw[0]) rate_sel = RATE_TAP0;
      else                 rate_sel = RATE_FULL;
   end

   always_ff @(posedge clk100 or negedge rst_n) begin
      if (!rst_n) begin
         phase  <= 1'b0;
         slow   <= '0;
         rate_q <= RATE_FULL;
      end else begin
         phase  <= ~phase;                 // clk100 / 2
         rate_q <= rate_sel;               // switches are asynchronous
         if (phase)
            slow <= slow + 1'b1;
      end
   end

   // slow bits up to and including the tap
   always_comb begin
      case (rate_q)
         RATE_TAP0:  tap_mask = SLOW_WIDTH'(19'h00001);
         RATE_TAP1:  tap_mask = SLOW_WIDTH'(19'h00003);
         RATE_TAP2:  tap_mask = SLOW_WIDTH'(19'h00007);
         RATE_TAP4:  tap_mask = SLOW_WIDTH'(19'h0001f);
         RATE_TAP5:  tap_mask = SLOW_WIDTH'(19'h0003f);
         RATE_TAP6:  tap_mask = SLOW_WIDTH'(19'h0007f);
         RATE_TAP18: tap_mask = SLOW_WIDTH'(19'h7ffff);
         default:    tap_mask = '0;         // full rate, every clk50 enable
      endcase
   end

   assign clk50_en = phase;
   assign cpu_step = phase && ((slow & tap_mask) == tap_mask);

endmodule

`default_nettype wire

// ==== hdl/panel_pkg.sv ====
// front panel display definitions and hex digit to segment decoding
`default_nettype none

package panel_pkg;

   typedef enum logic [1:0] {
      DIG0,   // rightmost digit, pc[3:0]
      DIG1,
      DIG2,
      DIG3    // leftmost digit, top nibble
   } digit_t;

   localparam int SCAN_CYCLES = 64;                   // clk100 cycles per digit
   localparam int SCAN_WIDTH  = $clog2(SCAN_CYCLES);

   // ----------------------------------------
   // segments g f e d c b a, active high
   // ----------------------------------------
   function automatic logic [6:0] hex_to_seg(input logic [3:0] value);
      logic [6:0] seg;
      case (value)
         4'h0:    seg = 7'h3f;
         4'h1:    seg = 7'h06;
         4'h2:    seg = 7'h5b;
         4'h3:    seg = 7'h4f;
         4'h4:    seg = 7'h66;
         4'h5:    seg = 7'h6d;
         4'h6:    seg = 7'h7d;
         4'h7:    seg = 7'h07;
         4'h8:    seg = 7'h7f;
         4'h9:    seg = 7'h6f;
         4'ha:    seg = 7'h77;
         4'hb:    seg = 7'h7c;   // lower case b
         4'hc:    seg = 7'h39;
         4'hd:    seg = 7'h5e;   // lower case d
         4'he:    seg = 7'h79;
         default: seg = 7'h71;   // F
      endcase
      return seg;
   endfunction

endpackage

`default_nettype wire

// ==== hdl/board_pkg.sv ====
// board clocking and reset sequencing definitions shared by the support logic
`default_nettype none

package board_pkg;

   // ----------------------------------------
   // step rate
   // ----------------------------------------
   typedef enum logic [2:0] {
      RATE_FULL,   // cpu step on every clk50 enable
      RATE_TAP0,
      RATE_TAP1,
      RATE_TAP2,
      RATE_TAP4,
      RATE_TAP5,
      RATE_TAP6,
      RATE_TAP18   // slow enough to follow on the leds
   } step_rate_t;

   localparam int SLOW_WIDTH = 23;          // free-running slow counter

   // ----------------------------------------
   // reset / boot sequencing
   // ----------------------------------------
   typedef enum logic [1:0] {
      SEQ_DCM,     // clocks settling
      SEQ_RESET,   // cpu held in reset
      SEQ_BOOT,    // single boot pulse
      SEQ_RUN
   } seq_state_t;

   localparam int DCM_RESET_CYCLES = 8;
   localparam int RESET_CYCLES     = 16;
   localparam int DEBOUNCE_CYCLES  = 16;    // stable cycles before a level is accepted
   localparam int SEQ_CNT_WIDTH    = $clog2(RESET_CYCLES);
   localparam int DEBOUNCE_WIDTH   = $clog2(DEBOUNCE_CYCLES);

endpackage

`default_nettype wire
